// File: include/sigencode_z_settings.svh
// Signature z encoder constants
`ifndef SIGENCODE_Z_SETTINGS_SVH
`define SIGENCODE_Z_SETTINGS_SVH

// ML-DSA prime modulus
`define SIGZ_Q 8380417

// Log2 of gamma1 for the only supported parameter set
`define SIGZ_GAMMA1_LOG 19

// Coefficient width, enough to hold any value below q
`define SIGZ_COEFF_W 23

// Encoded field width, gamma1 - z spans 0 to 2^20 - 1
`define SIGZ_ENC_W 20

// Coefficients per input beat
`define SIGZ_LANES 4
`define SIGZ_POLY_N 256
`define SIGZ_WORD_W 128
`define SIGZ_BEATS_PER_POLY 64

`endif

// File: hw/sigencode_z_pkg.sv
// Signature z encoder types
`include "sigencode_z_settings.svh"

package sigencode_z_pkg;

    // ----------------------------------------
    // Coefficient and field types
    // ----------------------------------------

    // One coefficient modulo q
    typedef logic [`SIGZ_COEFF_W-1:0] coeff_t;

    // One encoded field of the packed signature
    typedef logic [`SIGZ_ENC_W-1:0] zenc_t;

    // Lane 0 carries the lowest-indexed coefficient and sits in the low bits
    typedef coeff_t [`SIGZ_LANES-1:0] coeff_vec_t;
    typedef zenc_t [`SIGZ_LANES-1:0] zenc_vec_t;

    // ----------------------------------------
    // Output word and counters
    // ----------------------------------------
    typedef logic [`SIGZ_WORD_W-1:0] word_t;

    // Beat index inside one polynomial, 64 beats
    typedef logic [$clog2(`SIGZ_BEATS_PER_POLY)-1:0] beat_cnt_t;

    // Gearbox phase, eight 80-bit groups make exactly five 128-bit words
    typedef logic [2:0] group_cnt_t;

endpackage

// File: hw/z_coeff_loader.sv
// Coefficient input loader
`timescale 1ns/100ps
`include "sigencode_z_settings.svh"

module z_coeff_loader import sigencode_z_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize_i,
    input  logic       coeff_valid_i,
    input  coeff_vec_t coeff_i,
    output logic       ld_valid_o,
    output coeff_vec_t ld_coeff_o,
    output logic       ld_last_o
);

    // Index of the beat that is sampled next
    beat_cnt_t beat_cnt;

    // High while the beat now on the input closes a polynomial
    logic      beat_is_last;

    assign beat_is_last = (beat_cnt == beat_cnt_t'(`SIGZ_BEATS_PER_POLY - 1));

    // ----------------------------------------
    // Control state
    // ----------------------------------------

    // Zeroize drops whatever beat is on the input in the same cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ld_valid_o <= 1'b0;
            ld_last_o  <= 1'b0;
            beat_cnt   <= '0;
        end else if (zeroize_i) begin
            ld_valid_o <= 1'b0;
            ld_last_o  <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            ld_valid_o <= coeff_valid_i;
            // The last flag only travels with a valid beat
            ld_last_o  <= coeff_valid_i & beat_is_last;
            if (coeff_valid_i) begin
                // The 6-bit count wraps to zero after the 64th beat
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Beat payload, only loaded when a beat is present
    always_ff @(posedge clk) begin
        if (coeff_valid_i) begin
            ld_coeff_o <= coeff_i;
        end
    end

endmodule

// File: hw/sigencode_z_unit.sv
// Encode lane for one z coefficient
`timescale 1ns/100ps
`include "sigencode_z_settings.svh"

module sigencode_z_unit import sigencode_z_pkg::*; (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  coeff_t data_i,
    output zenc_t  data_o
);

    // Gamma1 and q as coefficient-width constants
    localparam coeff_t GAMMA1 = coeff_t'(1) << `SIGZ_GAMMA1_LOG;
    localparam coeff_t MOD_Q  = coeff_t'(`SIGZ_Q);

    // Stage one result, gamma1 - z in two's complement with its carry-out
    coeff_t diff;
    logic   diff_carry;

    // Stage register
    coeff_t diff_reg;
    logic   carry_reg;

    // Stage two result, the difference brought back into range by q
    coeff_t diff_plus_q;

    // ----------------------------------------
    // Stage one
    // ----------------------------------------

    // Subtraction as gamma1 + ~z + 1
    // A carry-out means z <= gamma1 and the difference is already non-negative
    assign {diff_carry, diff} = {1'b0, GAMMA1} + {1'b0, ~data_i} + 24'd1;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            diff_reg  <= '0;
            carry_reg <= 1'b0;
        end else if (zeroize_i) begin
            diff_reg  <= '0;
            carry_reg <= 1'b0;
        end else begin
            diff_reg  <= diff;
            carry_reg <= diff_carry;
        end
    end

    // ----------------------------------------
    // Stage two
    // ----------------------------------------

    // When z > gamma1 the difference wrapped around 2^23
    // Adding q wraps it back to gamma1 - z + q within 23 bits
    assign diff_plus_q = diff_reg + MOD_Q;

    // Final pick is combinational after the stage register
    // Both candidates fit in 20 bits, so the upper bits are simply dropped
    always_comb begin
        if (carry_reg) begin
            data_o = diff_reg[`SIGZ_ENC_W-1:0];
        end else begin
            data_o = diff_plus_q[`SIGZ_ENC_W-1:0];
        end
    end

endmodule

// File: hw/z_encode_array.sv
// Four-lane z encode array
`timescale 1ns/100ps
`include "sigencode_z_settings.svh"

module z_encode_array import sigencode_z_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize_i,
    input  logic       ld_valid_i,
    input  coeff_vec_t ld_coeff_i,
    input  logic       ld_last_i,
    output logic       enc_valid_o,
    output zenc_vec_t  enc_data_o,
    output logic       enc_last_o
);

    // ----------------------------------------
    // Encode lanes
    // ----------------------------------------

    // Each lane holds one register stage, so the fields are valid one edge
    // after the loader presents the beat
    for (genvar lane = 0; lane < `SIGZ_LANES; lane++) begin : g_lane
        sigencode_z_unit u_unit (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .data_i    (ld_coeff_i[lane]),
            .data_o    (enc_data_o[lane])
        );
    end

    // ----------------------------------------
    // Valid and last delay
    // ----------------------------------------

    // Matches the lane stage register so the strobes line up with the fields
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enc_valid_o <= 1'b0;
            enc_last_o  <= 1'b0;
        end else if (zeroize_i) begin
            enc_valid_o <= 1'b0;
            enc_last_o  <= 1'b0;
        end else begin
            enc_valid_o <= ld_valid_i;
            enc_last_o  <= ld_valid_i & ld_last_i;
        end
    end

endmodule

// File: hw/z_word_packer.sv
// Encoded field word packer
`timescale 1ns/100ps
`include "sigencode_z_settings.svh"

module z_word_packer import sigencode_z_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      zeroize_i,
    input  logic      enc_valid_i,
    input  zenc_vec_t enc_data_i,
    input  logic      enc_last_i,
    output logic      word_valid_o,
    output word_t     word_o,
    output logic      word_last_o
);

    // Bits in one beat of encoded fields
    localparam int GROUP_W = `SIGZ_ENC_W * `SIGZ_LANES;

    // Pending bits plus one new group need at most 112 + 80 bits
    localparam int COMB_W = `SIGZ_WORD_W + GROUP_W;

    // Pending bits sit aligned at bit 0 and never number more than 112
    word_t               pend_buf;
    group_cnt_t          phase;

    // Fill level of the buffer before the group of this phase is added
    logic [7:0]          fill;
    logic [7:0]          fill_sum;
    logic [COMB_W-1:0]   combined;
    logic                emit;

    // ----------------------------------------
    // Gearbox arithmetic
    // ----------------------------------------

    // Each phase adds 80 bits and every emit takes 128,
    // so the fill level follows from the phase alone
    always_comb begin
        case (phase)
            3'd0:    fill = 8'd0;
            3'd1:    fill = 8'd80;
            3'd2:    fill = 8'd32;
            3'd3:    fill = 8'd112;
            3'd4:    fill = 8'd64;
            3'd5:    fill = 8'd16;
            3'd6:    fill = 8'd96;
            default: fill = 8'd48;
        endcase
    end

    assign fill_sum = fill + 8'(GROUP_W);

    // Phases 1, 3, 4, 6 and 7 reach a full word
    assign emit = (fill_sum >= 8'(`SIGZ_WORD_W));

    // The new group lands directly above the pending bits
    assign combined = {{GROUP_W{1'b0}}, pend_buf}
                    | ({{`SIGZ_WORD_W{1'b0}}, enc_data_i} << fill);

    // ----------------------------------------
    // Buffer, phase and output strobes
    // ----------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pend_buf     <= '0;
            phase        <= '0;
            word_valid_o <= 1'b0;
            word_last_o  <= 1'b0;
        end else if (zeroize_i) begin
            pend_buf     <= '0;
            phase        <= '0;
            word_valid_o <= 1'b0;
            word_last_o  <= 1'b0;
        end else begin
            word_valid_o <= enc_valid_i & emit;
            word_last_o  <= enc_valid_i & emit & enc_last_i;
            if (enc_valid_i) begin
                if (emit) begin
                    // The remainder moves down and is empty after phase 7
                    pend_buf <= word_t'(combined[COMB_W-1:`SIGZ_WORD_W]);
                end else begin
                    pend_buf <= combined[`SIGZ_WORD_W-1:0];
                end
                // The last group of a polynomial always restarts the gearbox
                if (enc_last_i) begin
                    phase <= '0;
                end else begin
                    phase <= phase + 1'b1;
                end
            end
        end
    end

    // The word payload is the lowest 128 bits of the combined buffer
    always_ff @(posedge clk) begin
        if (enc_valid_i && emit) begin
            word_o <= combined[`SIGZ_WORD_W-1:0];
        end
    end

endmodule

// File: hw/sigencode_z_top.sv
// Signature z encoder top level
`timescale 1ns/100ps
`include "sigencode_z_settings.svh"

module sigencode_z_top import sigencode_z_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize_i,
    input  logic       coeff_valid_i,
    input  coeff_vec_t coeff_i,
    output logic       word_valid_o,
    output word_t      word_o,
    output logic       word_last_o
);

    // ----------------------------------------
    // Internal connections
    // ----------------------------------------

    // Loader to encode array
    logic       ld_valid;
    coeff_vec_t ld_coeff;
    logic       ld_last;

    // Encode array to packer
    logic       enc_valid;
    zenc_vec_t  enc_data;
    logic       enc_last;

    // Registers each beat and marks the 64th one
    z_coeff_loader u_loader (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .coeff_valid_i (coeff_valid_i),
        .coeff_i       (coeff_i),
        .ld_valid_o    (ld_valid),
        .ld_coeff_o    (ld_coeff),
        .ld_last_o     (ld_last)
    );

    // Four lanes of gamma1 - z
    z_encode_array u_array (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .ld_valid_i  (ld_valid),
        .ld_coeff_i  (ld_coeff),
        .ld_last_i   (ld_last),
        .enc_valid_o (enc_valid),
        .enc_data_o  (enc_data),
        .enc_last_o  (enc_last)
    );

    // Gearbox from 80-bit groups to 128-bit words
    z_word_packer u_packer (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .enc_valid_i  (enc_valid),
        .enc_data_i   (enc_data),
        .enc_last_i   (enc_last),
        .word_valid_o (word_valid_o),
        .word_o       (word_o),
        .word_last_o  (word_last_o)
    );

endmodule

// File: testbench/z_checker.sv
// Signature z encoder checker
`timescale 1ns/100ps
`include "sigencode_z_settings.svh"

module z_checker import sigencode_z_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize_i,
    input  logic       coeff_valid_i,
    input  coeff_vec_t coeff_i,
    input  logic       word_valid_i,
    input  word_t      word_i,
    input  logic       word_last_i,
    input  logic       test_done_i,
    input  int         test_id_i,
    input  int         test_words_i,
    output int         pending_o,
    output int         error_cnt_o,
    output int         word_cnt_o
);

    // Expected words in output order, the last flag sits in bit 128
    logic [128:0] exp_q[$];
    logic [128:0] exp_entry;

    // Bits of the current polynomial that do not fill a word yet
    logic [255:0] acc;
    int           acc_bits;
    int           poly_words;
    logic [79:0]  group;

    // Totals for the whole run and for the running test
    int errors = 0;
    int words = 0;
    int test_words = 0;
    int test_errors = 0;

    assign error_cnt_o = errors;
    assign word_cnt_o  = words;

    // gamma1 - z, brought back into range by q when z is above gamma1
    function automatic zenc_t encode_field(input coeff_t z);
        int diff;
        diff = (1 << `SIGZ_GAMMA1_LOG) - int'(z);
        if (diff < 0) begin
            diff = diff + `SIGZ_Q;
        end
        return zenc_t'(diff);
    endfunction

    always @(posedge clk) begin
        if (!reset_n) begin
            exp_q.delete();
            acc        = '0;
            acc_bits   = 0;
            poly_words = 0;
        end else begin
            // ----------------------------------------
            // Output side
            // ----------------------------------------
            if (word_last_i && !word_valid_i) begin
                $display("%0t: word_last_o was high without word_valid_o", $time);
                errors++;
                test_errors++;
            end
            if (word_valid_i) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: unexpected extra word %h", $time, word_i);
                    errors++;
                    test_errors++;
                end else begin
                    exp_entry = exp_q.pop_front();
                    if (word_i !== exp_entry[127:0]) begin
                        $display("CHECK FAILED word_o: got %h expected %h",
                                 word_i, exp_entry[127:0]);
                        errors++;
                        test_errors++;
                    end
                    if (word_last_i !== exp_entry[128]) begin
                        $display("CHECK FAILED word_last_o: got %h expected %h",
                                 word_last_i, exp_entry[128]);
                        errors++;
                        test_errors++;
                    end
                    words++;
                    test_words++;
                end
            end

            // ----------------------------------------
            // Input side
            // ----------------------------------------

            // Zeroize drops the partial polynomial and the beat sampled with it
            if (zeroize_i) begin
                acc        = '0;
                acc_bits   = 0;
                poly_words = 0;
            end else if (coeff_valid_i) begin
                for (int l = 0; l < `SIGZ_LANES; l++) begin
                    group[20*l +: 20] = encode_field(coeff_i[l]);
                end
                // Coefficient i owns bits 20i to 20i+19 of the bit string
                acc = acc | ({176'd0, group} << acc_bits);
                acc_bits += 80;
                if (acc_bits >= `SIGZ_WORD_W) begin
                    poly_words++;
                    exp_q.push_back({poly_words == 40, acc[127:0]});
                    if (poly_words == 40) begin
                        poly_words = 0;
                    end
                    acc = acc >> `SIGZ_WORD_W;
                    acc_bits -= `SIGZ_WORD_W;
                end
            end

            // Close the running test and compare its word count
            if (test_done_i) begin
                if (test_words != test_words_i) begin
                    $display("test %0d produced %0d words where %0d were expected",
                             test_id_i, test_words, test_words_i);
                    errors++;
                    test_errors++;
                end
                $display("test %0d finished: %0d words, %0d errors",
                         test_id_i, test_words, test_errors);
                test_words  = 0;
                test_errors = 0;
            end
        end
        pending_o = exp_q.size();
    end

endmodule

// File: testbench/tb_sigencode_z.sv
// Signature z encoder testbench
`timescale 1ns/100ps
`include "sigencode_z_settings.svh"

module tb_sigencode_z import sigencode_z_pkg::*; ();

    localparam int ROWS       = 6;
    localparam int PAT_EDGE   = 0;
    localparam int PAT_RANDOM = 1;
    localparam int PAT_ASCEND = 2;

    // Edge values, encoded 80000 7ffff 1 0 fe000 0 80001 in hex
    localparam int EDGE_Z [7] = '{0, 1, 524287, 524288, 524289, 7856129, 8380416};

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------

    // Zeroize at beat 30 leaves 18 words out and drops 96 pending bits
    string         row_name [ROWS] = '{"edge", "ascending", "random", "random_gaps",
                                       "zeroize_mid", "zeroize_early"};
    localparam int ROW_PAT   [ROWS] = '{PAT_EDGE, PAT_ASCEND, PAT_RANDOM, PAT_RANDOM,
                                        PAT_RANDOM, PAT_EDGE};
    localparam int ROW_POLYS [ROWS] = '{1, 1, 3, 2, 2, 1};
    localparam int ROW_GAP   [ROWS] = '{0, 0, 0, 40, 10, 0};
    localparam int ROW_ZERO  [ROWS] = '{-1, -1, -1, -1, 30, 1};
    localparam int ROW_WORDS [ROWS] = '{40, 40, 120, 80, 98, 40};

    logic        clk;
    logic        reset_n;
    logic        zeroize;
    logic        coeff_valid;
    coeff_vec_t  coeff;
    logic        word_valid;
    word_t       word_data;
    logic        word_last;
    logic        test_done;
    int          test_id;
    int          pending;
    int          error_cnt;
    int          word_cnt;
    int          timeouts;
    logic [31:0] rnd_state;

    sigencode_z_top u_dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize),
        .coeff_valid_i (coeff_valid),
        .coeff_i       (coeff),
        .word_valid_o  (word_valid),
        .word_o        (word_data),
        .word_last_o   (word_last)
    );

    z_checker u_chk (
        .clk (clk), .reset_n (reset_n), .zeroize_i (zeroize),
        .coeff_valid_i (coeff_valid), .coeff_i (coeff),
        .word_valid_i (word_valid), .word_i (word_data), .word_last_i (word_last),
        .test_done_i (test_done), .test_id_i (test_id),
        .test_words_i (ROW_WORDS[test_id]),
        .pending_o (pending), .error_cnt_o (error_cnt), .word_cnt_o (word_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Coefficient number index of a polynomial under the given pattern
    function automatic coeff_t pick_coeff(input int pattern, input int index);
        if (pattern == PAT_EDGE) begin
            return coeff_t'(EDGE_Z[index % 7]);
        end else if (pattern == PAT_ASCEND) begin
            return coeff_t'(index * 32749);
        end
        rnd_state = xorshift32(rnd_state);
        return coeff_t'(rnd_state % `SIGZ_Q);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            coeff_valid = 1'b0;
        end
    endtask

    // Beats restart at coefficient 0 every 64 beats, idle gaps come from the row
    task automatic send_beats(input int row, input int count);
        for (int b = 0; b < count; b++) begin
            rnd_state = xorshift32(rnd_state);
            if (rnd_state % 100 < ROW_GAP[row]) begin
                idle_cycles(int'(rnd_state[9:8]) + 1);
            end
            @(negedge clk);
            for (int l = 0; l < `SIGZ_LANES; l++) begin
                coeff[l] = pick_coeff(ROW_PAT[row], (b % 64) * 4 + l);
            end
            coeff_valid = 1'b1;
        end
        idle_cycles(1);
    endtask

    task automatic wait_drain(input int row);
        int cycles;
        cycles = 0;
        while (pending != 0 && cycles < 500) begin
            idle_cycles(1);
            cycles++;
        end
        if (pending != 0) begin
            $display("timeout in test %0d: %0d expected words never appeared", row, pending);
            timeouts++;
        end
    endtask

    initial begin
        reset_n     = 1'b0;
        zeroize     = 1'b0;
        coeff_valid = 1'b0;
        coeff       = '0;
        test_done   = 1'b0;
        test_id     = 0;
        timeouts    = 0;
        rnd_state   = 32'd85323;
        repeat (8) @(negedge clk);
        reset_n = 1'b1;
        // Quiet period, any word here is flagged as extra
        idle_cycles(6);
        for (int r = 0; r < ROWS; r++) begin
            $display("running test %0d %s", r, row_name[r]);
            if (ROW_ZERO[r] >= 0) begin
                send_beats(r, ROW_ZERO[r]);
                idle_cycles(4);
                // A beat presented with zeroize must be dropped
                @(negedge clk);
                zeroize     = 1'b1;
                coeff_valid = 1'b1;
                coeff       = '1;
                @(negedge clk);
                zeroize     = 1'b0;
                coeff_valid = 1'b0;
            end
            send_beats(r, ROW_POLYS[r] * `SIGZ_BEATS_PER_POLY);
            wait_drain(r);
            idle_cycles(5);
            @(negedge clk);
            test_id   = r;
            test_done = 1'b1;
            @(negedge clk);
            test_done = 1'b0;
        end
        idle_cycles(2);
        $display("words checked %0d, errors %0d, timeouts %0d", word_cnt, error_cnt, timeouts);
        if (error_cnt == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
hw/sigencode_z_pkg.sv
hw/z_coeff_loader.sv
hw/sigencode_z_unit.sv
hw/z_encode_array.sv
hw/z_word_packer.sv
hw/sigencode_z_top.sv
testbench/z_checker.sv
testbench/tb_sigencode_z.sv

// File: Makefile
# Verilator build and run for the signature z encoder

TOP := tb_sigencode_z

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
